// ==== tb/stbuf_patterns.txt ====
# op addr size data exp_byteen exp_data flags(drain_valid,full,empty), all hex but size
# size 0 byte, 1 half, 2 word; head is checked on drain ops, fwd on query ops
idle        0000 0 00000000 0 00000000 1
store       0100 2 a1a2a3a4 0 00000000 4
store       0204 2 b1b2b3b4 0 00000000 4
drain       0100 0 00000000 f a1a2a3a4 4
drain       0204 0 00000000 f b1b2b3b4 1
store       0302 0 000000cc 0 00000000 4
store       0300 1 0000dd11 0 00000000 4
store       0302 0 00000077 0 00000000 4
query       0301 0 00000000 7 0077dd11 4
query       0500 0 00000000 0 00000000 4
drain       0300 0 00000000 7 0077dd11 1
store       0400 2 11111111 0 00000000 4
store       0404 1 00002222 0 00000000 4
store       0408 2 33333333 0 00000000 4
store       040e 1 00004444 0 00000000 6
query       040c 0 00000000 c 44440000 6
store       0402 1 00005555 0 00000000 6
drain       0400 0 00000000 f 55551111 4
drain       0404 0 00000000 3 00002222 4
drain       0408 0 00000000 f 33333333 4
drain       040c 0 00000000 c 44440000 1
store       0600 2 12345678 0 00000000 4
store_drain 0602 0 000000ab f 12345678 4
drain       0600 0 00000000 4 00ab0000 1
query       0600 0 00000000 0 00000000 1
idle        0000 0 00000000 0 00000000 1

// ==== store_buffer.f ====
logic/stbuf_pkg.sv
logic/stbuf_alloc.sv
logic/stbuf_entry.sv
logic/stbuf_drain.sv
logic/stbuf_fwd.sv
logic/store_buffer.sv
tb/store_buffer_tb.sv

// ==== tb/store_buffer_tb.sv ====
module store_buffer_tb;

   localparam int DEPTH = 4;

   logic                 clk;
   logic                 rst_n;
   stbuf_pkg::st_req_t   store_req;
   stbuf_pkg::ld_query_t ld_query;
   logic                 drain_ack;
   logic                 drain_valid;
   stbuf_pkg::entry_t    drain_head;
   stbuf_pkg::fwd_t      fwd;
   logic                 full;
   logic                 empty;

   // parsed pattern lines
   logic [8*12-1:0] op_q[$];
   logic [15:0]     addr_q[$];
   int              size_q[$];
   logic [31:0]     data_q[$];
   logic [3:0]      be_q[$];
   logic [31:0]     edata_q[$];
   logic [2:0]      flag_q[$];   // drain_valid, full, empty

   int   errors;
   int   tests_failed;
   int   n_ops;
   logic loaded;

   store_buffer #(
      .DEPTH (DEPTH)
   ) UUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .store_req   (store_req),
      .ld_query    (ld_query),
      .drain_ack   (drain_ack),
      .drain_valid (drain_valid),
      .drain_head  (drain_head),
      .fwd         (fwd),
      .full        (full),
      .empty       (empty)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   function automatic logic [31:0] lane_mask(input logic [3:0] be);
      logic [31:0] m;
      m = '0;
      for (int b = 0; b < stbuf_pkg::BYTE_WIDTH; b++) begin
         if (be[b]) m[8*b +: 8] = 8'hff;
      end
      return m;
   endfunction

   task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                  input logic [31:0] got);
      $display("[FAIL] t=%0t %s expected %h got %h", $time, sig, exp, got);
      errors++;
   endtask

   task automatic load_patterns(input int fd);
      string           line;
      logic [8*12-1:0] op;
      logic [15:0]     addr;
      int              size;
      logic [31:0]     data;
      logic [3:0]      be;
      logic [31:0]     edata;
      logic [2:0]      flags;
      int              rc;
      while ($fgets(line, fd)) begin
         if (line.len() < 2 || line[0] == "#") continue;
         rc = $sscanf(line, "%s %h %d %h %h %h %h", op, addr, size, data, be, edata, flags);
         if (rc != 7) begin
            $display("pattern line could not be parsed: %s", line);
            errors++;
         end else begin
            op_q.push_back(op);
            addr_q.push_back(addr);
            size_q.push_back(size);
            data_q.push_back(data);
            be_q.push_back(be);
            edata_q.push_back(edata);
            flag_q.push_back(flags);
         end
      end
   endtask

   // one operation over two cycles with a check after each edge
   task automatic run_op(input int k);
      stbuf_pkg::addr_u   a;
      stbuf_pkg::st_req_t req;
      logic [31:0]        mask;
      logic               is_store;
      logic               is_drain;
      int                 err_before;
      a          = addr_q[k];
      mask       = lane_mask(be_q[k]);
      is_store   = (op_q[k] == "store") || (op_q[k] == "store_drain");
      is_drain   = (op_q[k] == "drain") || (op_q[k] == "store_drain");
      err_before = errors;
      req.valid  = 1'b1;
      req.addr   = a;
      req.size   = stbuf_pkg::size_t'(size_q[k]);
      req.data   = data_q[k];

      @(posedge clk);
      if (is_store) store_req <= req;
      if (is_drain) drain_ack <= 1'b1;
      if (op_q[k] == "query") begin
         ld_query.valid <= 1'b1;
         ld_query.addr  <= a;
      end

      @(negedge clk);
      if (is_drain) begin   // head being popped
         if (drain_valid !== 1'b1) report_mismatch("drain_valid", 1, drain_valid);
         if (drain_head.word !== a.f.word)
            report_mismatch("drain_head.word", a.f.word, drain_head.word);
         if (drain_head.byteen !== be_q[k])
            report_mismatch("drain_head.byteen", be_q[k], drain_head.byteen);
         if ((drain_head.data & mask) !== edata_q[k])
            report_mismatch("drain_head.data", edata_q[k], drain_head.data & mask);
      end
      if (op_q[k] == "query") begin
         if (fwd.byteen !== be_q[k]) report_mismatch("fwd.byteen", be_q[k], fwd.byteen);
         if (be_q[k] == '0) begin
            if (fwd.data !== '0) report_mismatch("fwd.data", 0, fwd.data);
         end else if ((fwd.data & mask) !== edata_q[k]) begin
            report_mismatch("fwd.data", edata_q[k], fwd.data & mask);
         end
      end

      @(posedge clk);
      store_req <= '0;
      ld_query  <= '0;
      drain_ack <= 1'b0;

      @(negedge clk);
      if (drain_valid !== flag_q[k][2]) report_mismatch("drain_valid", flag_q[k][2], drain_valid);
      if (full !== flag_q[k][1]) report_mismatch("full", flag_q[k][1], full);
      if (empty !== flag_q[k][0]) report_mismatch("empty", flag_q[k][0], empty);

      if (errors == err_before) begin
         $display("op %0d %0s %h : ok", k, op_q[k], addr_q[k]);
      end else begin
         $display("op %0d %0s %h : mismatch", k, op_q[k], addr_q[k]);
         tests_failed++;
      end
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin : run
      int seed;
      int fd;
      int gap;
      store_req    = '0;
      ld_query     = '0;
      drain_ack    = 1'b0;
      rst_n        = 1'b0;
      errors       = 0;
      tests_failed = 0;
      loaded       = 1'b0;
      seed         = $urandom(32'h71b);

      fd = $fopen("tb/stbuf_patterns.txt", "r");
      if (fd == 0) begin
         $display("could not open the pattern file tb/stbuf_patterns.txt");
         errors++;
      end else begin
         load_patterns(fd);
         $fclose(fd);
      end
      n_ops  = op_q.size();
      loaded = 1'b1;

      repeat (10) @(posedge clk);
      rst_n <= 1'b1;

      for (int k = 0; k < n_ops; k++) begin
         gap = $urandom_range(3, 0);   // idle cycles between ops
         repeat (gap) @(posedge clk);
         run_op(k);
      end

      $display("%0d tests, %0d failed, %0d mismatches", n_ops, tests_failed, errors);
      if (errors == 0 && n_ops > 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // per-op budget of 20 cycles plus reset
   initial begin : watchdog
      wait (loaded);
      #((n_ops * 20 * 10) + (10 * 10) + 100);
      $display("timeout: the pattern run did not finish in the allowed time");
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== logic/store_buffer.sv ====
module store_buffer #(
   parameter int DEPTH = 4
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  stbuf_pkg::st_req_t   store_req,
   input  stbuf_pkg::ld_query_t ld_query,
   input  logic                 drain_ack,
   output logic                 drain_valid,
   output stbuf_pkg::entry_t    drain_head,
   output stbuf_pkg::fwd_t      fwd,
   output logic                 full,
   output logic                 empty
);

   stbuf_pkg::entry_t [DEPTH-1:0] entries;   // live state of every entry
   logic [DEPTH-1:0]              wr_en;
   logic [DEPTH-1:0]              clr;       // one-hot, head pop
   stbuf_pkg::entry_t             wr_data;

   // ----------------------------------------
   // allocation and coalescing
   // ----------------------------------------
   stbuf_alloc #(
      .DEPTH (DEPTH)
   ) u_alloc (
      .clk       (clk),
      .rst_n     (rst_n),
      .store_req (store_req),
      .entries   (entries),
      .clr       (clr),
      .wr_en     (wr_en),
      .wr_data   (wr_data)
   );

   // ----------------------------------------
   // entry storage
   // ----------------------------------------
   for (genvar i = 0; i < DEPTH; i++) begin : g_entry
      stbuf_entry u_entry (
         .clk     (clk),
         .rst_n   (rst_n),
         .wr_en   (wr_en[i]),
         .clr     (clr[i]),
         .wr_data (wr_data),
         .entry   (entries[i])
      );
   end

   // ----------------------------------------
   // drain side
   // ----------------------------------------
   stbuf_drain #(
      .DEPTH (DEPTH)
   ) u_drain (
      .clk         (clk),
      .rst_n       (rst_n),
      .entries     (entries),
      .drain_ack   (drain_ack),
      .drain_valid (drain_valid),
      .drain_head  (drain_head),
      .clr         (clr),
      .full        (full),
      .empty       (empty)
   );

   // load forwarding, zero latency
   stbuf_fwd #(
      .DEPTH (DEPTH)
   ) u_fwd (
      .ld_query (ld_query),
      .entries  (entries),
      .fwd      (fwd)
   );

endmodule

// ==== logic/stbuf_fwd.sv ====
module stbuf_fwd #(
   parameter int DEPTH = 4
) (
   input  stbuf_pkg::ld_query_t          ld_query,
   input  stbuf_pkg::entry_t [DEPTH-1:0] entries,
   output stbuf_pkg::fwd_t               fwd
);

   logic [DEPTH-1:0] match;

   // ----------------------------------------
   // word compare
   // ----------------------------------------
   for (genvar i = 0; i < DEPTH; i++) begin : g_match
      assign match[i] = ld_query.valid & entries[i].vld &
                        (entries[i].word == ld_query.addr.f.word);
   end

   // or-reduce over matches, zero when none hit
   always_comb begin
      fwd = '0;
      for (int i = 0; i < DEPTH; i++) begin
         if (match[i]) begin
            fwd.byteen = fwd.byteen | entries[i].byteen;
            fwd.data   = fwd.data | entries[i].data;
         end
      end
   end

   // coalescing in alloc keeps one live entry per word
   always_comb begin
      a_match_onehot: assert final ($onehot0(match))
         else $error("load matched several entries");
   end

endmodule

// ==== logic/stbuf_drain.sv ====
module stbuf_drain #(
   parameter int DEPTH = 4
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  stbuf_pkg::entry_t [DEPTH-1:0] entries,
   input  logic                          drain_ack,
   output logic                          drain_valid,
   output stbuf_pkg::entry_t             drain_head,
   output logic [DEPTH-1:0]              clr,
   output logic                          full,
   output logic                          empty
);

   localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_BITS = $clog2(DEPTH + 1);

   logic [PTR_BITS-1:0] rd_ptr;
   logic [CNT_BITS-1:0] count;   // valid entries
   logic                pop;

   // ----------------------------------------
   // head presentation
   // ----------------------------------------
   assign drain_head  = entries[rd_ptr];
   assign drain_valid = drain_head.vld;
   assign pop         = drain_ack & drain_valid;

   // one-hot clear of the head
   for (genvar i = 0; i < DEPTH; i++) begin : g_clr
      assign clr[i] = pop & (rd_ptr == PTR_BITS'(i));
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_ptr <= '0;
      end else if (pop) begin
         rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
   end

   // ----------------------------------------
   // occupancy
   // ----------------------------------------
   always_comb begin
      count = '0;
      for (int i = 0; i < DEPTH; i++) begin
         count = count + CNT_BITS'(entries[i].vld);
      end
   end

   assign full  = (count == CNT_BITS'(DEPTH));
   assign empty = (count == '0);

   // memory side may only pop a presented head
   a_ack_has_head: assert property (@(posedge clk) disable iff (!rst_n)
      drain_ack |-> drain_valid)
      else $error("drain_ack without drain_valid");

   // in-order drain: head empty means the whole buffer is empty
   a_head_order: assert property (@(posedge clk) disable iff (!rst_n)
      !drain_valid |-> empty)
      else $error("valid entries behind an empty head");

endmodule

// ==== logic/stbuf_entry.sv ====
module stbuf_entry (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              wr_en,
   input  logic              clr,
   input  stbuf_pkg::entry_t wr_data,
   output stbuf_pkg::entry_t entry
);

   logic                             vld_q;
   logic [stbuf_pkg::WORD_BITS-1:0]  word_q;
   logic [stbuf_pkg::BYTE_WIDTH-1:0] byteen_q;
   logic [stbuf_pkg::DATA_WIDTH-1:0] data_q;

   // ----------------------------------------
   // control state
   // ----------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q    <= 1'b0;
         byteen_q <= '0;
      end else if (clr) begin
         vld_q    <= 1'b0;
         byteen_q <= '0;   // next allocation starts clean
      end else if (wr_en) begin
         vld_q    <= 1'b1;
         byteen_q <= byteen_q | wr_data.byteen;  // merge
      end
   end

   // ----------------------------------------
   // payload
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (wr_en) begin
         word_q <= wr_data.word;
         // only newly written lanes change, older bytes stay
         for (int b = 0; b < stbuf_pkg::BYTE_WIDTH; b++) begin
            if (wr_data.byteen[b]) begin
               data_q[8*b +: 8] <= wr_data.data[8*b +: 8];
            end
         end
      end
   end

   always_comb begin
      entry.vld    = vld_q;
      entry.word   = word_q;
      entry.byteen = byteen_q;
      entry.data   = data_q;
   end

   // alloc masks cleared entries out of coalescing, drain owns clr
   a_wr_clr_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(wr_en && clr))
      else $error("entry written and cleared in one cycle");

endmodule

// ==== logic/stbuf_alloc.sv ====
module stbuf_alloc #(
   parameter int DEPTH = 4
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  stbuf_pkg::st_req_t                  store_req,
   input  stbuf_pkg::entry_t [DEPTH-1:0]       entries,
   input  logic [DEPTH-1:0]                    clr,
   output logic [DEPTH-1:0]                    wr_en,
   output stbuf_pkg::entry_t                   wr_data
);

   localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   logic [PTR_BITS-1:0]              wr_ptr;
   logic [DEPTH-1:0]                 match;      // coalesce candidates
   logic                             coalesce;
   logic                             alloc_en;   // new entry at wr_ptr
   logic [stbuf_pkg::BYTE_WIDTH-1:0] size_be;
   logic [stbuf_pkg::BYTE_WIDTH-1:0] new_be;
   logic [stbuf_pkg::DATA_WIDTH-1:0] lane_data;

   // ----------------------------------------
   // byte enables and lane placement
   // ----------------------------------------
   always_comb begin
      case (store_req.size)
         stbuf_pkg::SZ_BYTE: size_be = 4'b0001;
         stbuf_pkg::SZ_HALF: size_be = 4'b0011;
         stbuf_pkg::SZ_WORD: size_be = 4'b1111;
         default:            size_be = 4'b0000;
      endcase
   end

   assign new_be    = size_be << store_req.addr.f.off;
   assign lane_data = store_req.data << (8 * store_req.addr.f.off);

   // ----------------------------------------
   // coalesce match
   // ----------------------------------------
   // an entry being drained this cycle cannot take the store
   for (genvar i = 0; i < DEPTH; i++) begin : g_match
      assign match[i] = entries[i].vld & ~clr[i] &
                        (entries[i].word == store_req.addr.f.word);
   end

   assign coalesce = |match;
   assign alloc_en = store_req.valid & ~coalesce;

   for (genvar i = 0; i < DEPTH; i++) begin : g_wr_en
      assign wr_en[i] = store_req.valid &
                        (match[i] | (~coalesce & (wr_ptr == PTR_BITS'(i))));
   end

   always_comb begin
      wr_data        = '0;
      wr_data.vld    = store_req.valid;   // entries set vld themselves
      wr_data.word   = store_req.addr.f.word;
      wr_data.byteen = new_be;
      wr_data.data   = lane_data;
   end

   // write pointer, wraps at DEPTH
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
      end else if (alloc_en) begin
         wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------
   // a store while full has to coalesce, else it would overwrite a live entry
   a_alloc_free: assert property (@(posedge clk) disable iff (!rst_n)
      alloc_en |-> !entries[wr_ptr].vld)
      else $error("store allocated into a valid entry");

   a_store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      store_req.valid |->
         ((store_req.size == stbuf_pkg::SZ_BYTE) ||
          (store_req.size == stbuf_pkg::SZ_HALF && !store_req.addr.f.off[0]) ||
          (store_req.size == stbuf_pkg::SZ_WORD && store_req.addr.f.off == '0)))
      else $error("misaligned or bad size store");

endmodule

// ==== logic/stbuf_pkg.sv ====
package stbuf_pkg;

   // ----------------------------------------
   // widths
   // ----------------------------------------
   localparam int ADDR_BITS  = 16;  // byte address
   localparam int DATA_WIDTH = 32;
   localparam int BYTE_WIDTH = 4;   // byte lanes per word
   localparam int OFF_BITS   = 2;   // byte offset in word
   localparam int WORD_BITS  = ADDR_BITS - OFF_BITS;

   // access size of a store
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } size_t;

   // byte address, seen whole or split into word index and offset
   typedef union packed {
      logic [ADDR_BITS-1:0] raw;
      struct packed {
         logic [WORD_BITS-1:0] word;
         logic [OFF_BITS-1:0]  off;
      } f;
   } addr_u;

   // ----------------------------------------
   // packets
   // ----------------------------------------
   typedef struct packed {
      logic                  valid;  // one-cycle strobe
      addr_u                 addr;
      size_t                 size;
      logic [DATA_WIDTH-1:0] data;   // lane 0 aligned
   } st_req_t;

   typedef struct packed {
      logic                  vld;
      logic [WORD_BITS-1:0]  word;
      logic [BYTE_WIDTH-1:0] byteen;
      logic [DATA_WIDTH-1:0] data;
   } entry_t;

   typedef struct packed {
      logic  valid;
      addr_u addr;
   } ld_query_t;

   typedef struct packed {
      logic [BYTE_WIDTH-1:0] byteen;
      logic [DATA_WIDTH-1:0] data;
   } fwd_t;

endpackage
